// File: Bender.yml
package:
  name: axi_sram

sources:
  - files:
      - rtl/sram_pkg.sv
      - rtl/mem_port_if.sv
      - rtl/sram_slave_fsm.sv
      - rtl/wait_timer.sv
      - rtl/sram_array.sv
      - rtl/axi_sram.sv
  - target: simulation
    files:
      - verif/axi_sram_properties.sv
      - verif/axi_sram_tb.sv

// File: axi_sram.f
rtl/sram_pkg.sv
rtl/mem_port_if.sv
rtl/sram_slave_fsm.sv
rtl/wait_timer.sv
rtl/sram_array.sv
rtl/axi_sram.sv
verif/axi_sram_properties.sv
verif/axi_sram_tb.sv

// File: rtl/axi_sram.sv
`timescale 1ns/1ps

module axi_sram (
	input  logic            clk,
	input  logic            rst,
	// read address
	input  logic            arvalid,
	input  sram_pkg::addr_t araddr,
	output logic            arready,
	// read data
	output logic            rvalid,
	output sram_pkg::data_t rdata,
	output sram_pkg::resp_e rresp,
	input  logic            rready,
	// write address
	input  logic            awvalid,
	input  sram_pkg::addr_t awaddr,
	output logic            awready,
	// write data
	input  logic            wvalid,
	input  sram_pkg::data_t wdata,
	input  sram_pkg::strb_t wstrb,
	output logic            wready,
	// write response
	output logic            bvalid,
	output sram_pkg::resp_e bresp,
	input  logic            bready
);

	// controller to timer
	logic timer_start;
	logic timer_done;

	// controller to array
	mem_port_if mem_bus ();

	sram_slave_fsm ctrl0 (
		.clk         (clk),
		.rst         (rst),
		.arvalid     (arvalid),
		.araddr      (araddr),
		.arready     (arready),
		.rvalid      (rvalid),
		.rdata       (rdata),
		.rresp       (rresp),
		.rready      (rready),
		.awvalid     (awvalid),
		.awaddr      (awaddr),
		.awready     (awready),
		.wvalid      (wvalid),
		.wdata       (wdata),
		.wstrb       (wstrb),
		.wready      (wready),
		.bvalid      (bvalid),
		.bresp       (bresp),
		.bready      (bready),
		.timer_start (timer_start),
		.timer_done  (timer_done),
		.mem         (mem_bus.ctrl)
	);

	wait_timer timer0 (
		.clk   (clk),
		.rst   (rst),
		.start (timer_start),
		.done  (timer_done)
	);

	sram_array array0 (
		.clk  (clk),
		.port (mem_bus.mem)
	);

endmodule

// File: rtl/mem_port_if.sv
`timescale 1ns/1ps

interface mem_port_if;
	import sram_pkg::*;

	// one-cycle access strobe
	logic      en;
	// high for write, low for read
	logic      we;
	word_idx_t idx;
	data_t     wdata;
	strb_t     wstrb;
	// registered read word from the array
	data_t     rdata;

	// controller side
	modport ctrl (
		output en, we, idx, wdata, wstrb,
		input  rdata
	);

	// array side
	modport mem (
		input  en, we, idx, wdata, wstrb,
		output rdata
	);

endinterface

// File: rtl/sram_array.sv
`timescale 1ns/1ps

module sram_array (
	input logic     clk,
	mem_port_if.mem port
);
	import sram_pkg::*;

	localparam int unsigned LANES = $bits(strb_t);
	localparam int unsigned LANE_W = $bits(data_t) / LANES;

	// storage, contents undefined until written
	data_t mem [MEM_WORDS];

	// byte-lane writes
	always_ff @(posedge clk) begin
		if (port.en && port.we) begin
			for (int i = 0; i < LANES; i++) begin
				if (port.wstrb[i])
					mem[port.idx][i*LANE_W +: LANE_W] <= port.wdata[i*LANE_W +: LANE_W];
			end
		end
	end

	// registered read, held until the next read
	always_ff @(posedge clk) begin
		if (port.en && !port.we)
			port.rdata <= mem[port.idx];
	end

endmodule

// File: rtl/sram_pkg.sv
package sram_pkg;

	// bus and storage types
	typedef logic [31:0] addr_t;
	typedef logic [63:0] data_t;
	typedef logic [7:0]  strb_t;
	typedef logic [7:0]  word_idx_t;

	// array geometry
	localparam int unsigned MEM_WORDS = 256;

	// word index field of the byte address
	localparam int unsigned IDX_LSB = 3;
	localparam int unsigned IDX_MSB = 10;

	// wait states between request accept and array access
	localparam int unsigned ACCESS_WAIT = 2;
	// wide enough to hold ACCESS_WAIT
	localparam int unsigned WAIT_CNT_W = $clog2(ACCESS_WAIT + 1);

	// AXI response codes, only the two in use
	typedef enum logic [1:0] {
		OKAY   = 2'd0,
		SLVERR = 2'd2
	} resp_e;

	// controller states
	typedef enum logic [2:0] {
		IDLE,
		WAIT,
		ACCESS,
		READ_RESP,
		WRITE_RESP
	} ctrl_state_e;

	// request opcode held by the controller
	typedef enum logic {
		REQ_READ,
		REQ_WRITE
	} req_kind_e;

endpackage

// File: rtl/sram_slave_fsm.sv
`timescale 1ns/1ps

module sram_slave_fsm (
	input  logic            clk,
	input  logic            rst,
	input  logic            arvalid,
	input  sram_pkg::addr_t araddr,
	output logic            arready,
	output logic            rvalid,
	output sram_pkg::data_t rdata,
	output sram_pkg::resp_e rresp,
	input  logic            rready,
	input  logic            awvalid,
	input  sram_pkg::addr_t awaddr,
	output logic            awready,
	input  logic            wvalid,
	input  sram_pkg::data_t wdata,
	input  sram_pkg::strb_t wstrb,
	output logic            wready,
	output logic            bvalid,
	output sram_pkg::resp_e bresp,
	input  logic            bready,
	output logic            timer_start,
	input  logic            timer_done,
	mem_port_if.ctrl        mem
);
	import sram_pkg::*;

	ctrl_state_e state;
	ctrl_state_e state_nxt;

	// request presented this cycle
	logic      wr_req;
	logic      rd_req;
	logic      accept;
	req_kind_e acc_kind;
	addr_t     acc_addr;
	logic      acc_ok;

	// captured request
	req_kind_e req_kind;
	word_idx_t req_idx;
	data_t     req_wdata;
	strb_t     req_wstrb;
	logic      req_ok;
	resp_e     resp_q;

	// write needs both address and data, and wins over a read
	assign wr_req = awvalid && wvalid;
	assign rd_req = arvalid && !wr_req;

	// readies only in IDLE
	assign awready = (state == IDLE) && wr_req;
	assign wready  = (state == IDLE) && wr_req;
	assign arready = (state == IDLE) && rd_req;
	assign accept  = awready || arready;

	// pick the winning address
	assign acc_kind = wr_req ? REQ_WRITE : REQ_READ;
	assign acc_addr = wr_req ? awaddr : araddr;
	// upper address bits must be clear
	assign acc_ok   = (acc_addr[$bits(addr_t)-1:IDX_MSB+1] == '0);

	// request payload, loaded on the handshake
	always_ff @(posedge clk) begin
		if (accept) begin
			req_kind  <= acc_kind;
			req_idx   <= acc_addr[IDX_MSB:IDX_LSB];
			req_wdata <= wdata;
			req_wstrb <= wstrb;
			req_ok    <= acc_ok;
			resp_q    <= acc_ok ? OKAY : SLVERR;
		end
	end

	// state and timer kick
	always_ff @(posedge clk) begin
		if (rst) begin
			state       <= IDLE;
			timer_start <= 1'b0;
		end else begin
			state       <= state_nxt;
			// high for the first WAIT cycle only
			timer_start <= accept;
		end
	end

	always_comb begin
		state_nxt = state;
		unique case (state)
			IDLE: begin
				if (accept)
					state_nxt = WAIT;
			end
			WAIT: begin
				if (timer_done)
					state_nxt = ACCESS;
			end
			ACCESS: begin
				state_nxt = (req_kind == REQ_WRITE) ? WRITE_RESP : READ_RESP;
			end
			READ_RESP: begin
				if (rready)
					state_nxt = IDLE;
			end
			WRITE_RESP: begin
				if (bready)
					state_nxt = IDLE;
			end
			default: state_nxt = IDLE;
		endcase
	end

	// response valids follow the state, held until handshake
	assign rvalid = (state == READ_RESP);
	assign bvalid = (state == WRITE_RESP);
	assign rresp  = resp_q;
	assign bresp  = resp_q;
	// array word held since ACCESS, zero on error
	assign rdata  = (rvalid && req_ok) ? mem.rdata : '0;

	// array access, suppressed when out of range
	assign mem.en    = (state == ACCESS) && req_ok;
	assign mem.we    = (req_kind == REQ_WRITE);
	assign mem.idx   = req_idx;
	assign mem.wdata = req_wdata;
	assign mem.wstrb = req_wstrb;

endmodule

// File: rtl/wait_timer.sv
`timescale 1ns/1ps

module wait_timer (
	input  logic clk,
	input  logic rst,
	input  logic start,
	output logic done
);
	import sram_pkg::*;

	logic                  running;
	logic [WAIT_CNT_W-1:0] count;

	always_ff @(posedge clk) begin
		if (rst) begin
			running <= 1'b0;
			count   <= '0;
		end else if (!running) begin
			// start is ignored while counting
			if (start) begin
				running <= 1'b1;
				// start arrives one cycle after the handshake
				count   <= WAIT_CNT_W'(ACCESS_WAIT - 1);
			end
		end else if (count == '0) begin
			running <= 1'b0;
		end else begin
			count <= count - 1'b1;
		end
	end

	// one cycle, on the last count
	assign done = running && (count == '0);

endmodule

// File: verif/axi_sram_properties.sv
`timescale 1ns/1ps

module axi_sram_properties (
	input logic            clk,
	input logic            rst,
	input logic            arready,
	input logic            awready,
	input logic            wready,
	input logic            rvalid,
	input logic            rready,
	input sram_pkg::data_t rdata,
	input sram_pkg::resp_e rresp,
	input logic            bvalid,
	input logic            bready,
	input sram_pkg::resp_e bresp
);
	import sram_pkg::*;

	// one response channel at a time
	assert property (@(posedge clk) disable iff (rst) !(rvalid && bvalid))
		else $error("rvalid and bvalid high together");

	// no new request while a response is pending
	assert property (@(posedge clk) disable iff (rst)
		(rvalid || bvalid) |-> !(arready || awready || wready))
		else $error("ready raised while a response is pending");

	// read response held until rready
	assert property (@(posedge clk) disable iff (rst)
		(rvalid && !rready) |=> (rvalid && $stable(rdata) && $stable(rresp)))
		else $error("read response changed before its handshake");

	// write response held until bready
	assert property (@(posedge clk) disable iff (rst)
		(bvalid && !bready) |=> (bvalid && $stable(bresp)))
		else $error("write response changed before its handshake");

	// state settles on the first reset edge
	assert property (@(posedge clk)
		(rst && $past(rst)) |-> !(arready || awready || wready || rvalid || bvalid))
		else $error("ready or valid high during reset");

endmodule

bind axi_sram axi_sram_properties props0 (
	.clk     (clk),
	.rst     (rst),
	.arready (arready),
	.awready (awready),
	.wready  (wready),
	.rvalid  (rvalid),
	.rready  (rready),
	.rdata   (rdata),
	.rresp   (rresp),
	.bvalid  (bvalid),
	.bready  (bready),
	.bresp   (bresp)
);

// File: verif/axi_sram_tb.sv
`timescale 1ns/1ps

module axi_sram_tb;
	import sram_pkg::*;

	localparam int TIMEOUT  = 64;
	localparam int NUM_STIM = 12;

	// one bus request with its expected outcome
	typedef struct {
		req_kind_e kind;
		addr_t     addr;
		data_t     wdata;
		strb_t     strb;
		data_t     exp_data;
		resp_e     exp_resp;
	} stim_t;

	// word 8 at 0x40, word 255 at 0x7f8, bit 11 or 31 set means out of range
	stim_t stim [NUM_STIM] = '{
		'{REQ_WRITE, 32'h0000_0040, 64'h0123_4567_89ab_cdef, 8'hff, 64'h0, OKAY},
		'{REQ_READ,  32'h0000_0040, 64'h0, 8'h00, 64'h0123_4567_89ab_cdef, OKAY},
		// lanes 0 and 2 only
		'{REQ_WRITE, 32'h0000_0040, 64'hffee_ddcc_bbaa_9988, 8'h05, 64'h0, OKAY},
		'{REQ_READ,  32'h0000_0040, 64'h0, 8'h00, 64'h0123_4567_89aa_cd88, OKAY},
		'{REQ_WRITE, 32'h0000_07f8, 64'hdead_beef_0bad_f00d, 8'hff, 64'h0, OKAY},
		// aliases word 8, must not land
		'{REQ_WRITE, 32'h0000_0840, 64'h5555_5555_5555_5555, 8'hff, 64'h0, SLVERR},
		'{REQ_READ,  32'h0000_0840, 64'h0, 8'h00, 64'h0, SLVERR},
		'{REQ_READ,  32'h0000_0040, 64'h0, 8'h00, 64'h0123_4567_89aa_cd88, OKAY},
		'{REQ_READ,  32'h8000_07f8, 64'h0, 8'h00, 64'h0, SLVERR},
		'{REQ_READ,  32'h0000_07f8, 64'h0, 8'h00, 64'hdead_beef_0bad_f00d, OKAY},
		// upper four lanes
		'{REQ_WRITE, 32'h0000_07f8, 64'h1111_2222_3333_4444, 8'hf0, 64'h0, OKAY},
		'{REQ_READ,  32'h0000_07f8, 64'h0, 8'h00, 64'h1111_2222_0bad_f00d, OKAY}
	};

	logic  clk = 1'b0;
	logic  rst;
	logic  arvalid, arready, rvalid, rready;
	logic  awvalid, awready, wvalid, wready, bvalid, bready;
	addr_t araddr, awaddr;
	data_t rdata, wdata;
	strb_t wstrb;
	resp_e rresp, bresp;
	int    seed = 32'hd290;

	axi_sram dut0 (.*);

	always #50 clk = ~clk;

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display(">>> FAIL");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp)
			abort_run($sformatf("FAIL %0t %s expected %b got %b", $time, name, exp, act));
	endtask

	task automatic check_data(input string name, input data_t exp, input data_t act);
		if (act !== exp)
			abort_run($sformatf("FAIL %0t %s expected %h got %h", $time, name, exp, act));
	endtask

	task automatic check_resp(input string name, input resp_e exp, input resp_e act);
		if (act !== exp)
			abort_run($sformatf("FAIL %0t %s expected %s got %b", $time, name, exp.name(), act));
	endtask

	task automatic check_latency(input string name, input int exp, input int act);
		if (act != exp)
			abort_run($sformatf("FAIL %0t %s expected %0d got %0d", $time, name, exp, act));
	endtask

	// random ready bit for back-pressure
	function automatic logic coin();
		logic [31:0] r;
		r = $random(seed);
		return r[0];
	endfunction

	task automatic check_quiet_outputs();
		check_flag("arready", 1'b0, arready);
		check_flag("awready", 1'b0, awready);
		check_flag("wready", 1'b0, wready);
		check_flag("rvalid", 1'b0, rvalid);
		check_flag("bvalid", 1'b0, bvalid);
	endtask

	// called on the request handshake edge, returns on the response handshake edge
	task automatic wait_resp(input logic is_wr, output resp_e resp, output data_t data);
		int lat;
		int cnt;
		lat = 0;
		cnt = 0;
		@(negedge clk);
		while (!(is_wr ? bvalid : rvalid)) begin
			if (lat > TIMEOUT)
				abort_run("timeout waiting for a response valid");
			@(posedge clk);
			lat++;
			rready <= coin();
			bready <= coin();
			@(negedge clk);
		end
		// counted in edges after the request handshake
		check_latency("response latency", ACCESS_WAIT + 2, lat);
		resp = is_wr ? bresp : rresp;
		data = rdata;
		// hold phase, response must not move and a waiting read must not enter
		while (!(is_wr ? bready : rready)) begin
			cnt++;
			if (cnt > TIMEOUT)
				abort_run("timeout while holding the response under back-pressure");
			check_flag("arready", 1'b0, arready);
			@(posedge clk);
			rready <= coin();
			bready <= coin();
			@(negedge clk);
			check_flag(is_wr ? "bvalid" : "rvalid", 1'b1, is_wr ? bvalid : rvalid);
			check_resp(is_wr ? "bresp" : "rresp", resp, is_wr ? bresp : rresp);
			check_data("rdata", data, rdata);
		end
		@(posedge clk);
		rready <= 1'b0;
		bready <= 1'b0;
	endtask

	// rd_too keeps arvalid up alongside the write to the same address
	task automatic do_write(input addr_t a, input data_t d, input strb_t s,
			input logic rd_too, output resp_e resp);
		int    cnt;
		data_t unused;
		cnt = 0;
		@(posedge clk);
		awvalid <= 1'b1;
		wvalid  <= 1'b1;
		awaddr  <= a;
		wdata   <= d;
		wstrb   <= s;
		arvalid <= rd_too;
		araddr  <= a;
		@(negedge clk);
		while (!(awready && wready)) begin
			cnt++;
			if (cnt > TIMEOUT)
				abort_run("timeout waiting for awready and wready");
			@(negedge clk);
		end
		// write wins the same cycle
		check_flag("arready", 1'b0, arready);
		@(posedge clk);
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		wait_resp(1'b1, resp, unused);
	endtask

	task automatic do_read(input addr_t a, output resp_e resp, output data_t data);
		int cnt;
		cnt = 0;
		// already presented when it waited behind a write
		if (!arvalid) begin
			@(posedge clk);
			arvalid <= 1'b1;
			araddr  <= a;
		end
		@(negedge clk);
		while (!arready) begin
			cnt++;
			if (cnt > TIMEOUT)
				abort_run("timeout waiting for arready");
			@(negedge clk);
		end
		@(posedge clk);
		arvalid <= 1'b0;
		wait_resp(1'b0, resp, data);
	endtask

	initial begin
		resp_e resp;
		data_t data;
		rst     <= 1'b1;
		arvalid <= 1'b0;
		araddr  <= '0;
		rready  <= 1'b0;
		awvalid <= 1'b0;
		awaddr  <= '0;
		wvalid  <= 1'b0;
		wdata   <= '0;
		wstrb   <= '0;
		bready  <= 1'b0;
		repeat (15) begin
			@(posedge clk);
			@(negedge clk);
			check_quiet_outputs();
		end
		@(posedge clk);
		rst <= 1'b0;
		// first cycle out of reset
		@(negedge clk);
		check_quiet_outputs();
		for (int i = 0; i < NUM_STIM; i++) begin
			if (stim[i].kind == REQ_WRITE) begin
				do_write(stim[i].addr, stim[i].wdata, stim[i].strb, 1'b0, resp);
			end else begin
				do_read(stim[i].addr, resp, data);
				check_data("rdata", stim[i].exp_data, data);
			end
			check_resp(stim[i].kind == REQ_WRITE ? "bresp" : "rresp", stim[i].exp_resp, resp);
		end
		// write and read raised together, read must see the new word
		do_write(32'h0000_0100, 64'hcafe_f00d_1234_5678, 8'hff, 1'b1, resp);
		check_resp("bresp", OKAY, resp);
		do_read(32'h0000_0100, resp, data);
		check_data("rdata", 64'hcafe_f00d_1234_5678, data);
		check_resp("rresp", OKAY, resp);
		$display(">>> PASS");
		$finish;
	end

endmodule
